// File: list.f
+incdir+.
mips_isa_pkg.sv
mips_bus_pkg.sv
mips_fetch.sv
mips_inst_queue.sv
mips_execute.sv
mips_cpu_bus.sv
avalon_ram_model.sv
mips_cpu_bus_tb.sv

// File: Bender.yml
package:
  name: mips_cpu_bus

sources:
  - include_dirs:
      - .
    files:
      - mips_isa_pkg.sv
      - mips_bus_pkg.sv
      - mips_fetch.sv
      - mips_inst_queue.sv
      - mips_execute.sv
      - mips_cpu_bus.sv
  - target: test
    include_dirs:
      - .
    files:
      - avalon_ram_model.sv
      - mips_cpu_bus_tb.sv

// File: mips_cpu_bus_tb.sv
`timescale 1ns/1ns
`include "mips_config.svh"

module mips_cpu_bus_tb
    import mips_isa_pkg::*;
    import mips_bus_pkg::*;
();

    localparam int NUM_TESTS  = 7;
    localparam int PROG_WORDS = 6;
    localparam int CLK_NS     = 20;
    // up to 8 cycles per instruction plus slack for reset and halt checks
    localparam int TIMEOUT_NS = (NUM_TESTS * PROG_WORDS * 8 + 100) * CLK_NS;
    localparam word_t JR0 = 32'h0000_0008;  // jr $0
    localparam word_t NOP = 32'h0000_0000;  // sll $0,$0,0

    logic       clk;
    logic       rst_n;
    logic       active;
    word_t      register_v0;
    addr_t      address;
    logic       write;
    logic       read;
    logic       waitrequest;
    word_t      writedata;
    logic [3:0] byteenable;
    word_t      readdata;

    string names [NUM_TESTS];
    word_t progs [NUM_TESTS][PROG_WORDS];
    word_t expect_v0 [NUM_TESTS];
    int    rows;
    int    errors;
    int    failed_tests;

    mips_cpu_bus dut0 (.*);

    avalon_ram_model #(.SEED(8092)) ram0 (.*);

    always #(CLK_NS / 2) clk = !clk;

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, got %h", what, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string what, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, got %h", what, exp, act);
            errors++;
        end
    endtask

    task automatic check_byteenable(input string what, input logic [3:0] exp,
                                    input logic [3:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %b, got %b", what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s: expected %b, got %b", what, exp, act);
            errors++;
        end
    endtask

    // no stores in this core, so the write side of the bus stays idle
    task automatic inspect_bus(input string name);
        check_bit({name, " write"}, 1'b0, write);
        check_word({name, " writedata"}, '0, writedata);
        if (read)
            check_byteenable({name, " byteenable"}, 4'b1111, byteenable);
    endtask

    task automatic add_row(input string name, input word_t v0,
                           input word_t prog [PROG_WORDS]);
        names[rows]     = name;
        expect_v0[rows] = v0;
        progs[rows]     = prog;
        rows++;
    endtask

    task automatic build_table();
        // addiu $2,$0,2; addiu $3,$0,0x8166; sllv $2,$2,$3 -> 2 << 6
        add_row("sllv", 32'h0000_0080,
                '{32'h2402_0002, 32'h2403_8166, 32'h0062_1004, JR0, NOP, NOP});
        // $3 = -3, $4 = 0x105; addu $2,$3,$4 = 0x102; subu $2,$3,$2 wraps
        add_row("arith", 32'hffff_fefb,
                '{32'h2403_fffd, 32'h2404_0105, 32'h0064_1021, 32'h0062_1023, JR0, NOP});
        // ori gives 0x0000f0f0, addiu gives 0xffffff00; and, or, then xor into $2
        add_row("logic", 32'hffff_0ff0,
                '{32'h3403_f0f0, 32'h2404_ff00, 32'h0064_2824, 32'h0064_3025,
                  32'h00a6_1026, JR0});
        // lui $2,0x1234; ori $2,$2,0xabcd
        add_row("lui_ori", 32'h1234_abcd,
                '{32'h3c02_1234, 32'h3442_abcd, JR0, NOP, NOP, NOP});
        // $3 = 0x8765c321; andi 0xf00f -> 0xc001; sll 12 then srl 4
        add_row("andi_shift", 32'h00c0_0100,
                '{32'h3c03_8765, 32'h3463_c321, 32'h3064_f00f, 32'h0004_2b00,
                  32'h0005_1102, JR0});
        // addiu $2,$0,9; addiu $0,$0,5; addu $2,$0,$0
        add_row("zero_reg", 32'h0000_0000,
                '{32'h2402_0009, 32'h2400_0005, 32'h0000_1021, JR0, NOP, NOP});
        // jr $5 to 0x14 skips addiu $2,$2,0x100 at 0x10
        add_row("redirect", 32'h0000_0021,
                '{32'h2402_0001, 32'h2405_0014, 32'h00a0_0008, 32'h2442_0100,
                  32'h2442_0020, JR0});
    endtask

    task automatic run_test(input int t);
        int   errors_before;
        logic read_seen;
        errors_before = errors;
        read_seen     = 1'b0;
        @(posedge clk);
        rst_n <= 1'b0;
        ram0.fill();
        for (int i = 0; i < PROG_WORDS; i++)
            ram0.load_word(addr_t'(`MIPS_RESET_VECTOR + 4 * i), progs[t][i]);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit({names[t], " active after reset"}, 1'b1, active);
        check_bit({names[t], " read in release cycle"}, 1'b0, read);
        @(negedge clk);
        check_bit({names[t], " read after first edge"}, 1'b1, read);
        check_addr({names[t], " first read address"}, `MIPS_RESET_VECTOR, address);
        while (active !== 1'b0) begin  // falling active ends the program
            inspect_bus(names[t]);
            @(negedge clk);
        end
        check_word({names[t], " v0"}, expect_v0[t], register_v0);
        // a read already on the bus may still finish, later cycles stay idle
        for (int c = 0; c < 10; c++) begin
            @(negedge clk);
            if (c >= 5)
                read_seen = read_seen | read;
        end
        check_bit({names[t], " active 10 cycles after halt"}, 1'b0, active);
        check_bit({names[t], " read after halt"}, 1'b0, read_seen);
        if (errors == errors_before) begin
            $display("test %s ok", names[t]);
        end else begin
            $display("test %s FAILED with %0d errors", names[t], errors - errors_before);
            failed_tests++;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        rows         = 0;
        errors       = 0;
        failed_tests = 0;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("%0d tests run, %0d failed, %0d check errors",
                 NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the core never halted", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: avalon_ram_model.sv
`timescale 1ns/1ns

module avalon_ram_model
    import mips_isa_pkg::*;
    import mips_bus_pkg::*;
#(
    parameter int          WORDS = 64,
    parameter int unsigned SEED  = 1
) (
    input  logic       clk,
    input  logic       rst_n,
    input  addr_t      address,
    input  logic       read,
    output word_t      readdata,
    output logic       waitrequest
);

    localparam int IDX_W = $clog2(WORDS);

    word_t      mem [WORDS];
    logic [1:0] wait_left;  // wait cycles still owed to the current read

    // undefined opcode 6'h3f over the full word index, executes as a no-op
    task automatic fill();
        for (int i = 0; i < WORDS; i++)
            mem[i] = {6'h3f, 26'(i)};
    endtask

    task automatic load_word(input addr_t byte_addr, input word_t data);
        mem[byte_addr[IDX_W+1:2]] = data;
    endtask

    assign readdata    = mem[address[IDX_W+1:2]];  // valid once waitrequest drops
    assign waitrequest = read && (wait_left != 2'd0);

    initial begin
        void'($urandom(SEED));
        wait_left = 2'd0;
        forever begin
            @(posedge clk or negedge rst_n);
            if (!rst_n)
                wait_left <= 2'd0;
            else if (read && wait_left != 2'd0)
                wait_left <= wait_left - 2'd1;
            else if (read)
                wait_left <= 2'($urandom % 4);  // stretch for the next read, 0 to 3
        end
    end

endmodule

// File: mips_cpu_bus.sv
`timescale 1ns/1ns

module mips_cpu_bus
    import mips_isa_pkg::*;
    import mips_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    output logic       active,
    output word_t      register_v0,
    output addr_t      address,
    output logic       write,
    output logic       read,
    input  logic       waitrequest,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  word_t      readdata
);

    avm_req_t    avm_req;
    avm_rsp_t    avm_rsp;
    logic        push;
    logic        full;
    logic        pop;
    logic        valid;
    logic        redirect;
    logic        halted;
    fetch_item_t push_item;
    fetch_item_t head;
    addr_t       redirect_pc;

    // flat Avalon names at the port
    assign address    = avm_req.address;
    assign write      = avm_req.write;
    assign read       = avm_req.read;
    assign writedata  = avm_req.writedata;
    assign byteenable = avm_req.byteenable;
    assign avm_rsp    = '{readdata: readdata, waitrequest: waitrequest};

    assign active = !halted;

    mips_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .avm_req     (avm_req),
        .avm_rsp     (avm_rsp),
        .push        (push),
        .push_item   (push_item),
        .full        (full),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .halted      (halted)
    );

    mips_inst_queue u_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_item (push_item),
        .full      (full),
        .pop       (pop),
        .head      (head),
        .valid     (valid),
        .flush     (redirect)  // a jr empties the queue
    );

    mips_execute u_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .head        (head),
        .valid       (valid),
        .pop         (pop),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .halted      (halted),
        .register_v0 (register_v0)
    );

endmodule

// File: mips_execute.sv
`timescale 1ns/1ns
`include "mips_config.svh"

module mips_execute
    import mips_isa_pkg::*;
    import mips_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  fetch_item_t head,
    input  logic        valid,
    output logic        pop,
    output logic        redirect,
    output addr_t       redirect_pc,
    output logic        halted,
    output word_t       register_v0
);

    word_t    regs [32];
    instr_u   ir;
    word_t    rs_val;
    word_t    rt_val;
    word_t    imm_sext;
    word_t    imm_zext;
    word_t    result;
    reg_idx_t wr_idx;
    logic     wr_en;
    logic     is_jr;
    logic     fire;      // head instruction retires this cycle
    logic     halted_q;

    assign ir   = head.instr;
    assign fire = valid && !halted_q;
    assign pop  = fire;

    // $0 is hardwired to zero
    assign rs_val = (ir.r.rs == '0) ? '0 : regs[ir.r.rs];
    assign rt_val = (ir.r.rt == '0) ? '0 : regs[ir.r.rt];

    assign imm_sext = {{16{ir.i.imm[15]}}, ir.i.imm};
    assign imm_zext = {16'h0000, ir.i.imm};

    always_comb begin
        result = '0;
        wr_idx = ir.i.rt;  // I-type target by default
        wr_en  = 1'b0;
        is_jr  = 1'b0;
        case (ir.r.opcode)
            OP_SPECIAL: begin
                wr_idx = ir.r.rd;
                wr_en  = 1'b1;
                case (ir.r.funct)
                    F_SLL:  result = rt_val << ir.r.shamt;
                    F_SRL:  result = rt_val >> ir.r.shamt;
                    F_SLLV: result = rt_val << rs_val[4:0];  // low 5 bits only
                    F_SRLV: result = rt_val >> rs_val[4:0];
                    F_ADDU: result = rs_val + rt_val;
                    F_SUBU: result = rs_val - rt_val;
                    F_AND:  result = rs_val & rt_val;
                    F_OR:   result = rs_val | rt_val;
                    F_XOR:  result = rs_val ^ rt_val;
                    F_JR: begin
                        wr_en = 1'b0;
                        is_jr = 1'b1;
                    end
                    default: wr_en = 1'b0;  // unknown funct, no-op
                endcase
            end
            OP_ADDIU: begin
                result = rs_val + imm_sext;
                wr_en  = 1'b1;
            end
            OP_ANDI: begin
                result = rs_val & imm_zext;
                wr_en  = 1'b1;
            end
            OP_ORI: begin
                result = rs_val | imm_zext;
                wr_en  = 1'b1;
            end
            OP_LUI: begin
                result = {ir.i.imm, 16'h0000};
                wr_en  = 1'b1;
            end
            default: ;  // unsupported opcode, no-op
        endcase
    end

    // jr to the halt target stops the core instead of redirecting
    assign redirect    = fire && is_jr && (rs_val != `MIPS_HALT_TARGET);
    assign redirect_pc = rs_val;
    assign halted      = halted_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            halted_q <= 1'b0;
        else if (fire && is_jr && (rs_val == `MIPS_HALT_TARGET))
            halted_q <= 1'b1;  // sticky until reset
    end

    always_ff @(posedge clk) begin
        if (fire && wr_en && (wr_idx != '0))
            regs[wr_idx] <= result;
    end

    assign register_v0 = regs[2];

    // instructions come from word addresses only, a jr target included
    a_head_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> head.pc[1:0] == 2'b00)
        else $error("execute got an instruction from an unaligned address");

endmodule

// File: mips_inst_queue.sv
`timescale 1ns/1ns
`include "mips_config.svh"

module mips_inst_queue
    import mips_bus_pkg::*;
#(
    parameter int DEPTH = `MIPS_QUEUE_DEPTH
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push,
    input  fetch_item_t push_item,
    output logic        full,
    input  logic        pop,
    output fetch_item_t head,
    output logic        valid,
    input  logic        flush
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_item_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1))
            return '0;
        return p + PTR_W'(1);
    endfunction

    assign wr_en = push && !flush;  // flush drops whatever arrives with it
    assign rd_en = pop && valid && !flush;

    assign valid = (count != '0);
    // last entry is kept for the read still on the bus
    assign full  = (count >= CNT_W'(DEPTH - 1));
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= next_ptr(wr_ptr);
            if (rd_en)
                rd_ptr <= next_ptr(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: ;  // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= push_item;
    end

    // fetch must respect full, spare slot included
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> count != CNT_W'(DEPTH))
        else $error("push into a queue with no free entry");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> valid)
        else $error("pop from an empty queue");

endmodule

// File: mips_fetch.sv
`timescale 1ns/1ns
`include "mips_config.svh"

module mips_fetch
    import mips_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    output avm_req_t    avm_req,
    input  avm_rsp_t    avm_rsp,
    output logic        push,
    output fetch_item_t push_item,
    input  logic        full,
    input  logic        redirect,
    input  addr_t       redirect_pc,
    input  logic        halted
);

    addr_t pc;       // next address to fetch
    addr_t addr_q;   // address of the read on the bus
    logic  read_q;
    logic  stale_q;  // read on the bus belongs to a flushed path
    logic  done;     // transfer completes this cycle
    logic  issue;
    logic  start;

    assign done  = read_q && !avm_rsp.waitrequest;
    assign issue = !halted && !full && !redirect;  // queue has room incl. spare slot
    assign start = (!read_q || done) && issue;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= `MIPS_RESET_VECTOR;
            read_q  <= 1'b0;
            stale_q <= 1'b0;
        end else begin
            if (!read_q || done)
                read_q <= issue;
            if (start)
                pc <= pc + 32'd4;
            if (redirect)
                pc <= redirect_pc;  // issue is low here, no clash with start

            // Avalon has no abort, so a redirected read runs out and is dropped
            if (done)
                stale_q <= 1'b0;
            else if (redirect && read_q)
                stale_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            addr_q <= pc;
    end

    always_comb begin
        avm_req.address    = addr_q;
        avm_req.read       = read_q;
        avm_req.write      = 1'b0;     // instruction reads only
        avm_req.writedata  = '0;
        avm_req.byteenable = 4'b1111;
    end

    // data of a completing read is dropped if stale or redirected this cycle
    assign push            = done && !stale_q && !redirect && !halted;
    assign push_item.pc    = addr_q;
    assign push_item.instr = avm_rsp.readdata;

    // slave must hand back defined data when it lets a read through
    a_rdata_known: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !$isunknown(avm_rsp.readdata))
        else $error("read completed with unknown readdata");

endmodule

// File: mips_bus_pkg.sv
package mips_bus_pkg;

    import mips_isa_pkg::*;

    typedef logic [31:0] addr_t;  // byte address

    // master side of the Avalon-MM port, 70 bits
    typedef struct packed {
        addr_t      address;
        logic       read;
        logic       write;
        word_t      writedata;
        logic [3:0] byteenable;
    } avm_req_t;

    // slave side, 33 bits
    typedef struct packed {
        word_t readdata;
        logic  waitrequest;
    } avm_rsp_t;

    // one fetched instruction with the address it came from
    typedef struct packed {
        addr_t  pc;
        instr_u instr;
    } fetch_item_t;

endpackage

// File: mips_isa_pkg.sv
package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes in bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,  // R-type, decoded by funct
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f
    } opcode_e;

    // R-type funct field in bits 5:0
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SLLV = 6'h04,
        F_SRLV = 6'h06,
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26
    } funct_e;

    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic [4:0] shamt;
        funct_e   funct;
    } r_fields_t;

    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        logic [15:0] imm;
    } i_fields_t;

    // same word, read as R or I format depending on opcode
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

endpackage

// File: mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// first instruction fetch address after reset
`define MIPS_RESET_VECTOR 32'h0000_0004

// jr to this address stops the core
`define MIPS_HALT_TARGET 32'h0000_0000

// default instruction queue depth
// one entry stays spare for the read on the bus, so keep it at 2 or more
`define MIPS_QUEUE_DEPTH 4

`endif
